//--- Bender.yml
package:
  name: core_qpath

sources:
  # Shared packages and the config interface
  - common/core_data_pkg.sv
  - common/core_cfg_pkg.sv
  - common/core_cfg_if.sv
  # Design blocks
  - core_cfg/core_cfg_regs.sv
  - core_mac/core_mac.sv
  - core_quant/core_quant.sv
  # Top level core_top
  - verilog/core_top.sv
  # Testbench, top module tb_core_top
  - target: test
    files:
      - verif/core_checker.sv
      - verif/tb_core_top.sv

//--- common/core_cfg_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// Live configuration fields, static while data is in flight
// ~~~~~~~~~~~~~~~~~~~~

interface core_cfg_if;
    import core_cfg_pkg::*;

    logic [SCALE_W-1:0]       scale;
    logic signed [BIAS_W-1:0] bias;
    logic [SHIFT_W-1:0]       shift;
    logic [ACCU_NUM_W-1:0]    accu_num;

    // Register bank owns every field
    modport regs (
        output scale,
        output bias,
        output shift,
        output accu_num
    );

    // Accumulator needs only the group length
    modport mac (
        input accu_num
    );

    modport quant (
        input scale,
        input bias,
        input shift
    );

endinterface

//--- common/core_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Register map and field layout of the run configuration
// Fields take the low bits of a 32-bit write word
// ~~~~~~~~~~~~~~~~~~~~

package core_cfg_pkg;

    // Field widths
    localparam int SCALE_W    = 16;  // unsigned
    localparam int BIAS_W     = 32;  // signed
    localparam int SHIFT_W    = 5;
    localparam int ACCU_NUM_W = 8;

    localparam int CFG_ADDR_W = 2;

    // Register addresses
    typedef enum logic [CFG_ADDR_W-1:0] {
        SCALE    = 2'd0,
        BIAS     = 2'd1,
        SHIFT    = 2'd2,
        ACCU_NUM = 2'd3
    } cfg_addr_e;

    // Values after reset give a pass-through of single products
    localparam logic [SCALE_W-1:0]        SCALE_RST    = 16'd1;
    localparam logic signed [BIAS_W-1:0]  BIAS_RST     = 32'sd0;
    localparam logic [SHIFT_W-1:0]        SHIFT_RST    = 5'd0;
    localparam logic [ACCU_NUM_W-1:0]     ACCU_NUM_RST = 8'd1;

endpackage

//--- common/core_data_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Default datapath sizes for the compute core output path
// The accumulator must hold a full product, so ACC_W >= 2*A_W
// ~~~~~~~~~~~~~~~~~~~~

package core_data_pkg;

    // Activation and weight sample width, both signed
    localparam int A_W = 8;

    // Running sum width, wraps on overflow
    localparam int ACC_W = 24;

    // Quantized activation width, signed
    localparam int ODATA_W = 8;

    // Extra register stages behind the scale multiplier
    // Raise this when the ACC_W x scale product misses timing
    localparam int QUANT_SCALE_RETIMING = 2;

endpackage

//--- core_cfg/core_cfg_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// Write-only configuration bank, no read-back
// Writes during an active run are not guarded against
// ~~~~~~~~~~~~~~~~~~~~

module core_cfg_regs (
    input  logic                    clk,
    input  logic                    rstn,

    // Write port
    input  logic                    cfg_wr_en,
    input  core_cfg_pkg::cfg_addr_e cfg_addr,
    input  logic [31:0]             cfg_wdata,

    core_cfg_if.regs                cfg
);
    import core_cfg_pkg::*;

    // Scale and shift
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg.scale <= SCALE_RST;
            cfg.shift <= SHIFT_RST;
        end else if (cfg_wr_en) begin
            if (cfg_addr == SCALE) begin
                cfg.scale <= cfg_wdata[SCALE_W-1:0];
            end
            if (cfg_addr == SHIFT) begin
                cfg.shift <= cfg_wdata[SHIFT_W-1:0];
            end
        end
    end

    // Bias, signed two's complement
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg.bias <= BIAS_RST;
        end else if (cfg_wr_en && cfg_addr == BIAS) begin
            cfg.bias <= $signed(cfg_wdata[BIAS_W-1:0]);
        end
    end

    // Products per group
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg.accu_num <= ACCU_NUM_RST;
        end else if (cfg_wr_en) begin
            case (cfg_addr)
                ACCU_NUM: cfg.accu_num <= cfg_wdata[ACCU_NUM_W-1:0];
                default:  cfg.accu_num <= cfg.accu_num;
            endcase
        end
    end

endmodule

//--- core_mac/core_mac.sv
// ~~~~~~~~~~~~~~~~~~~~
// Group sum of accu_num sample products, 0 counts as 1
// Needs ACC_W >= 2*A_W; the sum wraps at ACC_W bits
// ~~~~~~~~~~~~~~~~~~~~

module core_mac #(
    parameter int A_W   = 8,
    parameter int ACC_W = 24
) (
    input  logic                    clk,
    input  logic                    rstn,

    // Sample pair, one per strobe
    input  logic signed [A_W-1:0]   a_data,
    input  logic signed [A_W-1:0]   w_data,
    input  logic                    in_valid,

    core_cfg_if.mac                 cfg,

    output logic signed [ACC_W-1:0] acc_data,
    output logic                    acc_valid
);
    import core_cfg_pkg::*;

    localparam int PROD_W = 2 * A_W;

    logic signed [PROD_W-1:0] prod_q;
    logic                     prod_valid;
    logic signed [ACC_W-1:0]  prod_ext;
    logic signed [ACC_W-1:0]  acc_sum;
    logic signed [ACC_W-1:0]  acc_next;
    logic [ACCU_NUM_W-1:0]    prod_cnt;
    logic [ACCU_NUM_W-1:0]    accu_eff;
    logic                     last_prod;

    // Product register
    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod_q <= a_data * w_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= in_valid;
        end
    end

    always_comb begin
        prod_ext  = prod_q;
        acc_next  = acc_sum + prod_ext;
        accu_eff  = (cfg.accu_num == '0) ? ACCU_NUM_W'(1) : cfg.accu_num;
        // >= keeps the group finite if the count shrinks mid-group
        last_prod = (prod_cnt >= accu_eff - ACCU_NUM_W'(1));
    end

    // Running sum and product count
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc_sum  <= '0;
            prod_cnt <= '0;
        end else if (prod_valid) begin
            if (last_prod) begin
                acc_sum  <= '0;
                prod_cnt <= '0;
            end else begin
                acc_sum  <= acc_next;
                prod_cnt <= prod_cnt + 1'b1;
            end
        end
    end

    // Group total, held until the next group closes
    always_ff @(posedge clk) begin
        if (prod_valid && last_prod) begin
            acc_data <= acc_next;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= prod_valid && last_prod;
        end
    end

endmodule

//--- core_qpath.f
common/core_data_pkg.sv
common/core_cfg_pkg.sv
common/core_cfg_if.sv
core_cfg/core_cfg_regs.sv
core_mac/core_mac.sv
core_quant/core_quant.sv
verilog/core_top.sv
verif/core_checker.sv
verif/tb_core_top.sv

//--- core_quant/core_quant.sv
// ~~~~~~~~~~~~~~~~~~~~
// Scale, bias, round-half-up shift and saturate, no stall
// Latency QUANT_SCALE_RETIMING + 4; one input per cycle
// Config fields must stay still while results are in flight
// ~~~~~~~~~~~~~~~~~~~~

module core_quant #(
    parameter int ACC_W                = 24,
    parameter int ODATA_W              = 8,
    parameter int QUANT_SCALE_RETIMING = 2
) (
    input  logic                      clk,
    input  logic                      rstn,

    core_cfg_if.quant                 cfg,

    input  logic signed [ACC_W-1:0]   idata,
    input  logic                      idata_valid,
    output logic signed [ODATA_W-1:0] odata,
    output logic                      odata_valid
);
    import core_cfg_pkg::*;

    // Signed input times unsigned scale fits ACC_W + SCALE_W bits
    localparam int PROD_W = ACC_W + SCALE_W;
    // One spare bit so the bias add cannot overflow
    localparam int SUM_W  = ((PROD_W > BIAS_W) ? PROD_W : BIAS_W) + 1;
    localparam int RT     = QUANT_SCALE_RETIMING;

    localparam logic signed [SUM_W-1:0] SAT_MAX = 2**(ODATA_W-1) - 1;
    localparam logic signed [SUM_W-1:0] SAT_MIN = -(2**(ODATA_W-1));

    // Entry 0 is the multiplier output, the rest are retiming copies
    logic signed [PROD_W-1:0] rt_data [RT+1];
    logic [RT:0]              rt_valid;

    logic signed [SUM_W-1:0]   bias_sum;
    logic                      round_bit;
    logic signed [SUM_W-1:0]   bias_q;
    logic                      round_q;
    logic                      bias_valid;
    logic signed [SUM_W-1:0]   shifted;
    logic signed [SUM_W-1:0]   shift_sum;
    logic signed [SUM_W-1:0]   shift_q;
    logic                      shift_valid;
    logic signed [ODATA_W-1:0] sat_data;

    // Scale multiply
    always_ff @(posedge clk) begin
        if (idata_valid) begin
            rt_data[0] <= idata * $signed({1'b0, cfg.scale});
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rt_valid[0] <= 1'b0;
        end else begin
            rt_valid[0] <= idata_valid;
        end
    end

    // Retiming chain behind the multiplier
    for (genvar i = 1; i <= RT; i++) begin : g_retime
        always_ff @(posedge clk) begin
            if (rt_valid[i-1]) begin
                rt_data[i] <= rt_data[i-1];
            end
        end

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                rt_valid[i] <= 1'b0;
            end else begin
                rt_valid[i] <= rt_valid[i-1];
            end
        end
    end

    // Bias add; round bit sits just below the shift point
    always_comb begin
        bias_sum  = rt_data[RT] + cfg.bias;
        round_bit = (cfg.shift == '0) ? 1'b0 : bias_sum[cfg.shift - 1'b1];
    end

    always_ff @(posedge clk) begin
        if (rt_valid[RT]) begin
            bias_q  <= bias_sum;
            round_q <= round_bit;
        end
    end

    // Arithmetic shift, then round half up
    always_comb begin
        shifted   = bias_q >>> cfg.shift;
        shift_sum = shifted + $signed({1'b0, round_q});
    end

    always_ff @(posedge clk) begin
        if (bias_valid) begin
            shift_q <= shift_sum;
        end
    end

    // Clamp to the signed output range
    always_comb begin
        if (shift_q > SAT_MAX) begin
            sat_data = SAT_MAX[ODATA_W-1:0];
        end else if (shift_q < SAT_MIN) begin
            sat_data = SAT_MIN[ODATA_W-1:0];
        end else begin
            sat_data = shift_q[ODATA_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (shift_valid) begin
            odata <= sat_data;
        end
    end

    // Valid pipeline, shifts every cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bias_valid  <= 1'b0;
            shift_valid <= 1'b0;
            odata_valid <= 1'b0;
        end else begin
            bias_valid  <= rt_valid[RT];
            shift_valid <= bias_valid;
            odata_valid <= shift_valid;
        end
    end

endmodule

//--- verif/core_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// Reference model and scoreboard at the core_top ports
// Assumes config writes only while no group is in flight
// ~~~~~~~~~~~~~~~~~~~~

module core_checker (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  logic                                    cfg_wr_en,
    input  core_cfg_pkg::cfg_addr_e                 cfg_addr,
    input  logic [31:0]                             cfg_wdata,
    input  logic signed [core_data_pkg::A_W-1:0]    a_data,
    input  logic signed [core_data_pkg::A_W-1:0]    w_data,
    input  logic                                    in_valid,
    input  logic signed [core_data_pkg::ODATA_W-1:0] out_data,
    input  logic                                    out_valid,
    output int                                      pending,
    output int                                      checks,
    output int                                      mismatch_errs,
    output int                                      extra_errs,
    output int                                      missing_errs
);
    timeunit 1ns;
    timeprecision 1ps;
    import core_cfg_pkg::*;
    import core_data_pkg::*;

    // Idle cycles allowed before the oldest result counts as lost
    localparam int MISS_LIMIT = 64;

    logic [SCALE_W-1:0]        m_scale;
    logic signed [BIAS_W-1:0]  m_bias;
    logic [SHIFT_W-1:0]        m_shift;
    logic [ACCU_NUM_W-1:0]     m_accu;
    logic signed [ACC_W-1:0]   m_sum;
    logic signed [ACC_W-1:0]   next_sum;
    logic signed [2*A_W-1:0]   prod;
    logic signed [ODATA_W-1:0] exp_val;
    logic signed [ODATA_W-1:0] exp_q [$];
    int                        m_cnt;
    int                        idle_cycles;

    // Scale, bias, round half up on the bit below the shift point, clamp
    function automatic logic signed [ODATA_W-1:0] quantize(
        input logic signed [ACC_W-1:0]  sum,
        input logic [SCALE_W-1:0]       scale,
        input logic signed [BIAS_W-1:0] bias,
        input logic [SHIFT_W-1:0]       shift
    );
        longint v;
        longint rb;
        longint hi;
        longint lo;
        v  = longint'(sum) * longint'(scale) + longint'(bias);
        rb = (shift == 0) ? 0 : ((v >>> (shift - 1)) & 1);
        v  = (v >>> shift) + rb;
        hi = 2**(ODATA_W-1) - 1;
        lo = -hi - 1;
        if (v > hi) v = hi;
        if (v < lo) v = lo;
        return ODATA_W'(v);
    endfunction

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            m_scale     = SCALE_RST;
            m_bias      = BIAS_RST;
            m_shift     = SHIFT_RST;
            m_accu      = ACCU_NUM_RST;
            m_sum       = '0;
            m_cnt       = 0;
            idle_cycles = 0;
            exp_q.delete();
        end else begin
            // Outputs against the oldest queued result
            if (out_valid) begin
                idle_cycles = 0;
                if (exp_q.size() == 0) begin
                    $display("ERROR: out_valid at %0t with no result expected", $time);
                    extra_errs++;
                end else begin
                    exp_val = exp_q.pop_front();
                    checks++;
                    if (out_data !== exp_val) begin
                        $display("FAIL out_data: got %h, expected %h", out_data, exp_val);
                        mismatch_errs++;
                    end
                end
            end else if (exp_q.size() != 0) begin
                idle_cycles++;
                if (idle_cycles > MISS_LIMIT) begin
                    $display("ERROR: expected result %h never appeared on out_data", exp_q[0]);
                    missing_errs++;
                    void'(exp_q.pop_front());
                    idle_cycles = 0;
                end
            end
            // Group sum, wraps at ACC_W bits
            if (in_valid) begin
                prod     = a_data * w_data;
                next_sum = m_sum + prod;
                if (m_cnt + 1 >= ((m_accu == 0) ? 1 : int'(m_accu))) begin
                    exp_q.push_back(quantize(next_sum, m_scale, m_bias, m_shift));
                    m_sum = '0;
                    m_cnt = 0;
                end else begin
                    m_sum = next_sum;
                    m_cnt++;
                end
            end
            // Mirror of the register bank, live from the next cycle
            if (cfg_wr_en) begin
                case (cfg_addr)
                    SCALE:    m_scale = cfg_wdata[SCALE_W-1:0];
                    BIAS:     m_bias  = cfg_wdata[BIAS_W-1:0];
                    SHIFT:    m_shift = cfg_wdata[SHIFT_W-1:0];
                    ACCU_NUM: m_accu  = cfg_wdata[ACCU_NUM_W-1:0];
                    default:  m_accu  = m_accu;
                endcase
            end
        end
        pending = exp_q.size();
    end

endmodule

//--- verif/tb_core_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench for core_top with default parameters
// Rows with a fixed pattern reuse its 4 pairs in turn
// ~~~~~~~~~~~~~~~~~~~~

module tb_core_top;
    timeunit 1ns;
    timeprecision 1ps;
    import core_cfg_pkg::*;
    import core_data_pkg::*;

    localparam int NROWS       = 8;
    localparam int DRAIN_LIMIT = 200;

    typedef struct packed {
        logic            write_cfg;
        logic [15:0]     scale;
        logic [31:0]     bias;
        logic [4:0]      shift;
        logic [7:0]      accu_num;
        logic [7:0]      groups;
        logic            fixed;
        logic [3:0][7:0] a_pat;
        logic [3:0][7:0] w_pat;
    } row_t;

    logic                      clk;
    logic                      rstn;
    logic                      cfg_wr_en;
    cfg_addr_e                 cfg_addr;
    logic [31:0]               cfg_wdata;
    logic signed [A_W-1:0]     a_data;
    logic signed [A_W-1:0]     w_data;
    logic                      in_valid;
    logic signed [ODATA_W-1:0] out_data;
    logic                      out_valid;
    int                        pending;
    int                        checks;
    int                        mismatch_errs;
    int                        extra_errs;
    int                        missing_errs;
    logic [31:0]               lfsr_state;
    row_t                      rows [NROWS];
    bit                        timed_out;

    core_top DUT (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_wr_en (cfg_wr_en),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .a_data    (a_data),
        .w_data    (w_data),
        .in_valid  (in_valid),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

    core_checker u_checker (
        .clk           (clk),
        .rstn          (rstn),
        .cfg_wr_en     (cfg_wr_en),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .a_data        (a_data),
        .w_data        (w_data),
        .in_valid      (in_valid),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .pending       (pending),
        .checks        (checks),
        .mismatch_errs (mismatch_errs),
        .extra_errs    (extra_errs),
        .missing_errs  (missing_errs)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_sample(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    task automatic write_reg(input cfg_addr_e addr, input logic [31:0] data);
        @(posedge clk);
        cfg_wr_en <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
    endtask

    task automatic apply_row(input row_t r);
        int          n_samp;
        logic [7:0]  a_s;
        logic [7:0]  w_s;
        n_samp = (r.accu_num == 0) ? 1 : int'(r.accu_num);
        if (r.write_cfg) begin
            write_reg(SCALE, 32'(r.scale));
            write_reg(BIAS, r.bias);
            write_reg(SHIFT, 32'(r.shift));
            write_reg(ACCU_NUM, 32'(r.accu_num));
            @(posedge clk);
            cfg_wr_en <= 1'b0;
        end
        repeat (2) @(posedge clk);
        // Back-to-back strobes so groups overlap in the pipeline
        for (int k = 0; k < n_samp * int'(r.groups); k++) begin
            if (r.fixed) begin
                a_s = r.a_pat[k % 4];
                w_s = r.w_pat[k % 4];
            end else begin
                draw_sample(a_s);
                draw_sample(w_s);
            end
            @(posedge clk);
            in_valid <= 1'b1;
            a_data   <= a_s;
            w_data   <= w_s;
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drained(output bit late);
        int c;
        c = 0;
        @(negedge clk);
        while (pending != 0 && c < DRAIN_LIMIT) begin
            @(negedge clk);
            c++;
        end
        late = (pending != 0);
    endtask

    initial begin
        rstn       = 1'b0;
        cfg_wr_en  = 1'b0;
        cfg_addr   = SCALE;
        cfg_wdata  = '0;
        a_data     = '0;
        w_data     = '0;
        in_valid   = 1'b0;
        lfsr_state = 32'hceff_0e02;
        timed_out  = 1'b0;
        // Reset defaults with single products saturating to 8 bits
        rows[0] = '{1'b0, 16'd1, 32'd0, 5'd0, 8'd1, 8'd4, 1'b1, 32'hf9_80_7f_03, 32'h09_7f_7f_05};
        // Four products per output
        rows[1] = '{1'b1, 16'd1, 32'd0, 5'd0, 8'd4, 8'd3, 1'b1, 32'h01_05_fd_0a, 32'hff_05_04_02};
        // Round bit set and clear for positive and negative sums
        rows[2] = '{1'b1, 16'd3, 32'd4, 5'd3, 8'd1, 8'd4, 1'b1, 32'hfd_fb_03_02, 32'h02_02_02_02};
        // Clamp to 7f and 80
        rows[3] = '{1'b1, 16'd100, 32'd0, 5'd4, 8'd2, 8'd4, 1'b1, 32'h80_80_7f_7f, 32'h7f_7f_7f_7f};
        rows[4] = '{1'b1, 16'd1234, -32'sd5000, 5'd10, 8'd8, 8'd10, 1'b0, 32'd0, 32'd0};
        rows[5] = '{1'b1, 16'd37, 32'd300, 5'd5, 8'd3, 8'd12, 1'b0, 32'd0, 32'd0};
        rows[6] = '{1'b1, 16'd65535, 32'd0, 5'd20, 8'd16, 8'd6, 1'b0, 32'd0, 32'd0};
        // Count 0 behaves as 1
        rows[7] = '{1'b1, 16'd7, -32'sd1, 5'd1, 8'd0, 8'd8, 1'b0, 32'd0, 32'd0};
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        for (int r = 0; r < NROWS && !timed_out; r++) begin
            apply_row(rows[r]);
            wait_drained(timed_out);
            if (timed_out) begin
                $display("ERROR: timeout in row %0d with %0d results still pending", r, pending);
            end
        end
        $display("Checks %0d, mismatches %0d, unexpected outputs %0d, missing outputs %0d",
                 checks, mismatch_errs, extra_errs, missing_errs);
        if (timed_out || mismatch_errs + extra_errs + missing_errs != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

//--- verilog/core_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Output path of one compute core: MAC, then quantizer
// Latency QUANT_SCALE_RETIMING + 6 from the last sample of a group
// No back-pressure; out_data must be taken while out_valid is high
// ~~~~~~~~~~~~~~~~~~~~

module core_top #(
    parameter int A_W                  = core_data_pkg::A_W,
    parameter int ACC_W                = core_data_pkg::ACC_W,
    parameter int ODATA_W              = core_data_pkg::ODATA_W,
    parameter int QUANT_SCALE_RETIMING = core_data_pkg::QUANT_SCALE_RETIMING
) (
    input  logic                      clk,
    input  logic                      rstn,

    // Configuration writes
    input  logic                      cfg_wr_en,
    input  core_cfg_pkg::cfg_addr_e   cfg_addr,
    input  logic [31:0]               cfg_wdata,

    // Sample stream
    input  logic signed [A_W-1:0]     a_data,
    input  logic signed [A_W-1:0]     w_data,
    input  logic                      in_valid,

    // Quantized activations
    output logic signed [ODATA_W-1:0] out_data,
    output logic                      out_valid
);

    core_cfg_if cfg_bus ();

    logic signed [ACC_W-1:0] acc_data;
    logic                    acc_valid;

    core_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_wr_en (cfg_wr_en),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg_bus.regs)
    );

    core_mac #(
        .A_W   (A_W),
        .ACC_W (ACC_W)
    ) u_mac (
        .clk       (clk),
        .rstn      (rstn),
        .a_data    (a_data),
        .w_data    (w_data),
        .in_valid  (in_valid),
        .cfg       (cfg_bus.mac),
        .acc_data  (acc_data),
        .acc_valid (acc_valid)
    );

    core_quant #(
        .ACC_W                (ACC_W),
        .ODATA_W              (ODATA_W),
        .QUANT_SCALE_RETIMING (QUANT_SCALE_RETIMING)
    ) u_quant (
        .clk         (clk),
        .rstn        (rstn),
        .cfg         (cfg_bus.quant),
        .idata       (acc_data),
        .idata_valid (acc_valid),
        .odata       (out_data),
        .odata_valid (out_valid)
    );

endmodule
